//--- Makefile
VERILATOR  := verilator
FLAGS      := --timing --assert
TOP        := pmu_apb_regs_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
design/pmu_bus_pkg.sv
design/pmu_ctrl_pkg.sv
design/pmu_apb_slave.sv
design/pmu_reg_bank.sv
design/pmu_pulse_stretch.sv
design/pmu_readback_mux.sv
design/pmu_apb_regs.sv
verification/pmu_apb_regs_tb.sv

//--- design/pmu_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pmu_apb_regs (
    input  wire logic                               pclk,
    input  wire logic                               prstn,
    input  wire logic                               psel,
    input  wire logic                               penable,
    input  wire logic                               pwrite,
    input  wire logic [pmu_bus_pkg::apb_addr_w-1:0] paddr,
    input  wire logic [pmu_bus_pkg::apb_data_w-1:0] pwdata,
    output logic      [pmu_bus_pkg::apb_data_w-1:0] prdata,
    output logic                                    pready,
    input  pmu_ctrl_pkg::pmu_status_t               status,
    output pmu_ctrl_pkg::analog_cfg_t               analog_cfg,
    output pmu_ctrl_pkg::adc_ctrl_t                 adc_ctrl,
    output pmu_ctrl_pkg::pmu_mode_t                 pmu_mode,
    output pmu_ctrl_pkg::boot_ctrl_t                boot_ctrl,
    output pmu_ctrl_pkg::irq_ctrl_t                 irq_ctrl
);

    import pmu_bus_pkg::*;
    import pmu_ctrl_pkg::*;

    reg_req_t              req;
    logic [apb_data_w-1:0] rdata;
    adc_ctrl_t             bank_adc;
    logic                  adc_trig_raw;
    logic                  adc_trig;

    pmu_apb_slave u_apb_slave (
        .pclk    (pclk),
        .prstn   (prstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .rdata   (rdata),
        .req     (req),
        .prdata  (prdata),
        .pready  (pready)
    );

    pmu_reg_bank u_reg_bank (
        .pclk         (pclk),
        .prstn        (prstn),
        .req          (req),
        .analog       (analog_cfg),
        .adc          (bank_adc),
        .mode         (pmu_mode),
        .boot         (boot_ctrl),
        .irq          (irq_ctrl),
        .adc_trig_raw (adc_trig_raw)
    );

    pmu_pulse_stretch #(
        .cycles (adc_trig_cycles)
    ) u_trig_stretch (
        .pclk      (pclk),
        .prstn     (prstn),
        .pulse_in  (adc_trig_raw),
        .pulse_out (adc_trig)
    );

    pmu_readback_mux u_readback (
        .addr   (req.addr),
        .analog (analog_cfg),
        .adc    (bank_adc),
        .mode   (pmu_mode),
        .boot   (boot_ctrl),
        .irq    (irq_ctrl),
        .status (status),
        .rdata  (rdata)
    );

    always_comb
    begin
        adc_ctrl         = bank_adc;
        adc_ctrl.trigger = adc_trig;  // ADC sees the stretched trigger
    end

endmodule

`default_nettype wire

//--- design/pmu_apb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module pmu_apb_slave (
    input  wire logic                                pclk,
    input  wire logic                                prstn,
    input  wire logic                                psel,
    input  wire logic                                penable,
    input  wire logic                                pwrite,
    input  wire logic [pmu_bus_pkg::apb_addr_w-1:0]  paddr,
    input  wire logic [pmu_bus_pkg::apb_data_w-1:0]  pwdata,
    input  wire logic [pmu_bus_pkg::apb_data_w-1:0]  rdata,
    output pmu_bus_pkg::reg_req_t                    req,
    output logic      [pmu_bus_pkg::apb_data_w-1:0]  prdata,
    output logic                                     pready
);

    import pmu_bus_pkg::*;

    logic setup;

    assign setup = psel && !penable;  // Setup phase of a transfer

    always_comb
    begin
        req.wr    = setup && pwrite;
        req.rd    = setup && !pwrite;
        req.addr  = paddr;
        req.wdata = pwdata;
    end

    // Read word is captured at the end of setup and held for the access phase
    always_ff @(posedge pclk or negedge prstn)
    begin
        if (!prstn)
            prdata <= '0;
        else if (req.rd)
            prdata <= rdata;
    end

    assign pready = 1'b1;             // Zero wait states

    property p_access_after_setup;
        @(posedge pclk) disable iff (!prstn)
        $rose(penable) |-> $past(psel && !penable);
    endproperty

    a_access_after_setup: assert property (p_access_after_setup)
        else $error("penable raised without a preceding setup cycle");

endmodule

`default_nettype wire

//--- design/pmu_bus_pkg.sv
`default_nettype none

package pmu_bus_pkg;

    localparam int apb_addr_w = 24;
    localparam int apb_data_w = 32;

    typedef logic [apb_addr_w-1:0] apb_addr_t;
    typedef logic [apb_data_w-1:0] apb_data_t;

    // Register map
    localparam apb_addr_t reg_bias_off   = 24'h00;
    localparam apb_addr_t reg_ldo_off    = 24'h04;
    localparam apb_addr_t reg_osc_off    = 24'h08;
    localparam apb_addr_t reg_sw_off     = 24'h0c;
    localparam apb_addr_t reg_wd_off     = 24'h10;
    localparam apb_addr_t reg_adc_off    = 24'h1c;
    localparam apb_addr_t reg_status_off = 24'h28;
    localparam apb_addr_t reg_mode_off   = 24'h40;
    localparam apb_addr_t reg_boot_off   = 24'h58;
    localparam apb_addr_t reg_int_off    = 24'h5c;

    // Request towards the register bank, one cycle per transfer
    typedef struct packed {
        logic      wr;                  // Write strobe, setup cycle only
        logic      rd;                  // Read strobe, setup cycle only
        apb_addr_t addr;
        apb_data_t wdata;
    } reg_req_t;

endpackage

`default_nettype wire

//--- design/pmu_ctrl_pkg.sv
`default_nettype none

package pmu_ctrl_pkg;

    // Bias, LDO, oscillators, power switches and watchdog
    typedef struct packed {
        logic [2:0] bg_trim;
        logic       en_temp;
        logic [5:0] iref_trim;
        logic       ldo_b_en;
        logic [3:0] ldo_s_vtrim;
        logic [3:0] ldo_b_vtrim;
        logic [6:0] osc32k_trim;
        logic [6:0] osc16m_trim;
        logic       osc16m_en;
        logic       sw_flash_pdn_en;
        logic       sw_flash_en;
        logic       sw_core_pdn_en;
        logic       sw_core_en;
        logic [1:0] wd_tsel;
        logic       wd_clrn;
    } analog_cfg_t;

    // Field order matches bits 14:0 of the ADC register
    typedef struct packed {
        logic       clk_sel;
        logic [3:0] ch_mux;
        logic [5:0] sample_cnt;
        logic       trigger;
        logic       mode;
        logic       en;
        logic       reg_sel;
    } adc_ctrl_t;

    typedef struct packed {
        logic [3:0] lpmd_sel;
        logic       suspend;
        logic       sleep;
    } pmu_mode_t;

    typedef struct packed {
        logic [2:0] soft_rst;
        logic [1:0] boot_sel;
    } boot_ctrl_t;

    typedef struct packed {
        logic        clr_en;            // Not visible in the read word
        logic [3:0]  clr;
        logic [11:0] trg;
        logic [3:0]  msk;
    } irq_ctrl_t;

    typedef struct packed {
        logic        ldo12_ready;
        logic        ldo_if_ready;
        logic        osc32k_ready;
        logic        osc16m_ready;
        logic [11:0] adc_data;
        logic [3:0]  int_sta;
    } pmu_status_t;

    localparam analog_cfg_t analog_cfg_rst = '{
        bg_trim: 3'h4, en_temp: 1'b0, iref_trim: 6'h28,
        ldo_b_en: 1'b1, ldo_s_vtrim: 4'hc, ldo_b_vtrim: 4'h8,
        osc32k_trim: 7'h54, osc16m_trim: 7'h59, osc16m_en: 1'b1,
        sw_flash_pdn_en: 1'b0, sw_flash_en: 1'b1,
        sw_core_pdn_en: 1'b0, sw_core_en: 1'b1,
        wd_tsel: 2'h1, wd_clrn: 1'b0
    };

    localparam adc_ctrl_t adc_ctrl_rst = '{
        clk_sel: 1'b0, ch_mux: 4'h0, sample_cnt: 6'h1, trigger: 1'b0,
        mode: 1'b0, en: 1'b0, reg_sel: 1'b0
    };

    localparam pmu_mode_t  pmu_mode_rst  = '{lpmd_sel: 4'h4, suspend: 1'b0, sleep: 1'b0};
    localparam boot_ctrl_t boot_ctrl_rst = '{soft_rst: 3'h4, boot_sel: 2'h0};
    localparam irq_ctrl_t  irq_ctrl_rst  = '0;

    localparam int adc_trig_cycles = 3;

endpackage

`default_nettype wire

//--- design/pmu_pulse_stretch.sv
`timescale 1ns/1ps
`default_nettype none

module pmu_pulse_stretch #(
    parameter int cycles = pmu_ctrl_pkg::adc_trig_cycles
) (
    input  wire logic pclk,
    input  wire logic prstn,
    input  wire logic pulse_in,
    output logic      pulse_out
);

    import pmu_ctrl_pkg::*;

    logic [cycles-1:0] hist;          // Past samples of pulse_in, newest in bit 0

    always_ff @(posedge pclk or negedge prstn)
    begin
        if (!prstn)
            hist <= '0;
        else
        begin
            hist[0] <= pulse_in;
            for (int i = 1; i < cycles; i++)
                hist[i] <= hist[i-1];
        end
    end

    assign pulse_out = |hist;

    // A quiet input for the full window must leave the output low
    a_stretch_len: assert property (
        @(posedge pclk) disable iff (!prstn) !pulse_in [*cycles] |=> !pulse_out)
        else $error("stretched pulse longer than %0d cycles", cycles);

endmodule

`default_nettype wire

//--- design/pmu_readback_mux.sv
`timescale 1ns/1ps
`default_nettype none

module pmu_readback_mux (
    input  wire logic [pmu_bus_pkg::apb_addr_w-1:0] addr,
    input  pmu_ctrl_pkg::analog_cfg_t                analog,
    input  pmu_ctrl_pkg::adc_ctrl_t                  adc,
    input  pmu_ctrl_pkg::pmu_mode_t                  mode,
    input  pmu_ctrl_pkg::boot_ctrl_t                 boot,
    input  pmu_ctrl_pkg::irq_ctrl_t                  irq,
    input  pmu_ctrl_pkg::pmu_status_t                status,
    output logic      [pmu_bus_pkg::apb_data_w-1:0] rdata
);

    import pmu_bus_pkg::*;
    import pmu_ctrl_pkg::*;

    always_comb
    begin
        case (addr)
            reg_bias_off:
                rdata = {22'h0, analog.bg_trim, analog.en_temp, analog.iref_trim};
            reg_ldo_off:
                rdata = {23'h0, analog.ldo_b_en, analog.ldo_s_vtrim, analog.ldo_b_vtrim};
            reg_osc_off:
                rdata = {17'h0, analog.osc32k_trim, analog.osc16m_trim, analog.osc16m_en};
            reg_sw_off:
                rdata = {28'h0, analog.sw_flash_pdn_en, analog.sw_flash_en,
                         analog.sw_core_pdn_en, analog.sw_core_en};
            reg_wd_off:
                rdata = {29'h0, analog.wd_tsel, analog.wd_clrn};
            reg_adc_off:
                rdata = {17'h0, adc};                     // Trigger shows the raw bit
            reg_status_off:
                rdata = {16'h0, status.ldo12_ready, status.ldo_if_ready,
                         status.osc32k_ready, status.osc16m_ready, status.adc_data};
            reg_mode_off:
                rdata = {26'h0, mode};
            reg_boot_off:
                rdata = {27'h0, boot};
            reg_int_off:
                rdata = {4'h0, status.int_sta, 4'h0, irq.clr, irq.trg, irq.msk};
            default:
                rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/pmu_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module pmu_reg_bank (
    input  wire logic               pclk,
    input  wire logic               prstn,
    input  pmu_bus_pkg::reg_req_t   req,
    output pmu_ctrl_pkg::analog_cfg_t analog,
    output pmu_ctrl_pkg::adc_ctrl_t   adc,
    output pmu_ctrl_pkg::pmu_mode_t   mode,
    output pmu_ctrl_pkg::boot_ctrl_t  boot,
    output pmu_ctrl_pkg::irq_ctrl_t   irq,
    output logic                      adc_trig_raw
);

    import pmu_bus_pkg::*;
    import pmu_ctrl_pkg::*;

    logic wr_bias;
    logic wr_ldo;
    logic wr_osc;
    logic wr_sw;
    logic wr_wd;
    logic wr_adc;
    logic wr_mode;
    logic wr_boot;
    logic wr_int;

    assign wr_bias = req.wr && (req.addr == reg_bias_off);
    assign wr_ldo  = req.wr && (req.addr == reg_ldo_off);
    assign wr_osc  = req.wr && (req.addr == reg_osc_off);
    assign wr_sw   = req.wr && (req.addr == reg_sw_off);
    assign wr_wd   = req.wr && (req.addr == reg_wd_off);
    assign wr_adc  = req.wr && (req.addr == reg_adc_off);
    assign wr_mode = req.wr && (req.addr == reg_mode_off);
    assign wr_boot = req.wr && (req.addr == reg_boot_off);
    assign wr_int  = req.wr && (req.addr == reg_int_off);

    always_ff @(posedge pclk or negedge prstn)
    begin
        if (!prstn)
        begin
            analog <= analog_cfg_rst;
            adc    <= adc_ctrl_rst;
            mode   <= pmu_mode_rst;
            boot   <= boot_ctrl_rst;
            irq    <= irq_ctrl_rst;
        end
        else
        begin
            // Write-to-pulse fields drop back unless written this cycle
            adc.trigger  <= 1'b0;
            mode.suspend <= 1'b0;
            mode.sleep   <= 1'b0;
            irq.clr_en   <= 1'b0;

            if (wr_bias)
            begin
                analog.bg_trim   <= req.wdata[9:7];
                analog.en_temp   <= req.wdata[6];
                analog.iref_trim <= req.wdata[5:0];
            end
            if (wr_ldo)
            begin
                analog.ldo_b_en    <= req.wdata[8];
                analog.ldo_s_vtrim <= req.wdata[7:4];
                analog.ldo_b_vtrim <= req.wdata[3:0];
            end
            if (wr_osc)
            begin
                analog.osc32k_trim <= req.wdata[14:8];
                analog.osc16m_trim <= req.wdata[7:1];
                analog.osc16m_en   <= req.wdata[0];
            end
            if (wr_sw)
            begin
                analog.sw_flash_pdn_en <= req.wdata[3];
                analog.sw_flash_en     <= req.wdata[2];
                analog.sw_core_pdn_en  <= req.wdata[1];
                analog.sw_core_en      <= req.wdata[0];
            end
            if (wr_wd)
            begin
                analog.wd_tsel <= req.wdata[2:1];
                analog.wd_clrn <= req.wdata[0];
            end
            if (wr_adc)
            begin
                adc.clk_sel    <= req.wdata[14];
                adc.ch_mux     <= req.wdata[13:10];
                adc.sample_cnt <= req.wdata[9:4];
                adc.trigger    <= req.wdata[3];
                adc.mode       <= req.wdata[2];
                adc.en         <= req.wdata[1];
                adc.reg_sel    <= req.wdata[0];
            end
            if (wr_mode)
            begin
                mode.lpmd_sel <= req.wdata[5:2];
                mode.suspend  <= req.wdata[1];
                mode.sleep    <= req.wdata[0];
            end
            if (wr_boot)
            begin
                boot.soft_rst <= req.wdata[4:2];
                boot.boot_sel <= req.wdata[1:0];
            end
            if (wr_int)
            begin
                irq.clr_en <= |req.wdata[19:16];  // Only a non-zero clear request
                irq.clr    <= req.wdata[19:16];
                irq.trg    <= req.wdata[15:4];
                irq.msk    <= req.wdata[3:0];
            end
        end
    end

    assign adc_trig_raw = adc.trigger;

    // Pulse fields are one cycle long only for a single-cycle write strobe
    a_wr_strobe_single: assert property (
        @(posedge pclk) disable iff (!prstn) req.wr |=> !req.wr)
        else $error("write strobe held for more than one cycle");

endmodule

`default_nettype wire

//--- verification/pmu_apb_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pmu_apb_regs_tb;

    import pmu_bus_pkg::*;
    import pmu_ctrl_pkg::*;

    localparam int clk_period = 20;
    localparam int rst_cycles = 8;
    localparam int n_xfers    = 80;     // Upper bound over all tests
    localparam int timeout_ns = (rst_cycles + n_xfers * 3 + 50) * clk_period;

    logic                  pclk;
    logic                  prstn;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    pmu_status_t           status;
    analog_cfg_t           analog_cfg;
    adc_ctrl_t             adc_ctrl;
    pmu_mode_t             pmu_mode;
    boot_ctrl_t            boot_ctrl;
    irq_ctrl_t             irq_ctrl;

    integer seed = 84;
    int     errors = 0;
    int     checks = 0;

    pmu_apb_regs uut (
        .pclk       (pclk),
        .prstn      (prstn),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .status     (status),
        .analog_cfg (analog_cfg),
        .adc_ctrl   (adc_ctrl),
        .pmu_mode   (pmu_mode),
        .boot_ctrl  (boot_ctrl),
        .irq_ctrl   (irq_ctrl)
    );

    always #(clk_period / 2) pclk = ~pclk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic drive_setup(input logic wr, input logic [23:0] addr, input logic [31:0] data);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
    endtask

    task automatic drive_access();
        @(negedge pclk);
        penable = 1'b1;
        check_bit("pready", pready, 1'b1);   // Zero wait states
    endtask

    task automatic drive_idle();
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [23:0] addr, input logic [31:0] data);
        drive_setup(1'b1, addr, data);
        drive_access();
        drive_idle();
    endtask

    task automatic apb_read(input logic [23:0] addr, output logic [31:0] data);
        drive_setup(1'b0, addr, '0);
        drive_access();
        data = prdata;                  // Held through the access phase
        drive_idle();
    endtask

    task automatic read_expect(input logic [23:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        apb_read(addr, rd);
        check_val($sformatf("prdata@0x%02h", addr), rd, exp);
    endtask

    function automatic logic [23:0] rw_offset(input int idx);
        case (idx)
            0: rw_offset = reg_bias_off;
            1: rw_offset = reg_ldo_off;
            2: rw_offset = reg_osc_off;
            3: rw_offset = reg_sw_off;
            4: rw_offset = reg_wd_off;
            5: rw_offset = reg_adc_off;
            6: rw_offset = reg_mode_off;
            7: rw_offset = reg_boot_off;
            default: rw_offset = reg_int_off;
        endcase
    endfunction

    // Writable bits that read back, pulse bits cleared
    function automatic logic [31:0] rw_mask(input logic [23:0] addr);
        case (addr)
            reg_bias_off: rw_mask = 32'h0000_03ff;
            reg_ldo_off:  rw_mask = 32'h0000_01ff;
            reg_osc_off:  rw_mask = 32'h0000_7fff;
            reg_sw_off:   rw_mask = 32'h0000_000f;
            reg_wd_off:   rw_mask = 32'h0000_0007;
            reg_adc_off:  rw_mask = 32'h0000_7ff7;
            reg_mode_off: rw_mask = 32'h0000_003c;
            reg_boot_off: rw_mask = 32'h0000_001f;
            reg_int_off:  rw_mask = 32'h000f_ffff;
            default:      rw_mask = 32'h0;
        endcase
    endfunction

    // Output struct fields laid out at their register bit positions
    function automatic logic [31:0] output_view(input logic [23:0] addr);
        case (addr)
            reg_bias_off: output_view = {22'h0, analog_cfg.bg_trim, analog_cfg.en_temp,
                                         analog_cfg.iref_trim};
            reg_ldo_off:  output_view = {23'h0, analog_cfg.ldo_b_en, analog_cfg.ldo_s_vtrim,
                                         analog_cfg.ldo_b_vtrim};
            reg_osc_off:  output_view = {17'h0, analog_cfg.osc32k_trim, analog_cfg.osc16m_trim,
                                         analog_cfg.osc16m_en};
            reg_sw_off:   output_view = {28'h0, analog_cfg.sw_flash_pdn_en, analog_cfg.sw_flash_en,
                                         analog_cfg.sw_core_pdn_en, analog_cfg.sw_core_en};
            reg_wd_off:   output_view = {29'h0, analog_cfg.wd_tsel, analog_cfg.wd_clrn};
            reg_adc_off:  output_view = {17'h0, adc_ctrl.clk_sel, adc_ctrl.ch_mux,
                                         adc_ctrl.sample_cnt, 1'b0, adc_ctrl.mode,
                                         adc_ctrl.en, adc_ctrl.reg_sel};
            reg_mode_off: output_view = {26'h0, pmu_mode.lpmd_sel, 2'b00};
            reg_boot_off: output_view = {27'h0, boot_ctrl.soft_rst, boot_ctrl.boot_sel};
            reg_int_off:  output_view = {12'h0, irq_ctrl.clr, irq_ctrl.trg, irq_ctrl.msk};
            default:      output_view = 32'h0;
        endcase
    endfunction

    task automatic test_reset_values();
        check_val("prdata", prdata, 32'h0);
        check_bit("adc_ctrl.trigger", adc_ctrl.trigger, 1'b0);
        check_bit("irq_ctrl.clr_en", irq_ctrl.clr_en, 1'b0);
        check_bit("pmu_mode.sleep", pmu_mode.sleep, 1'b0);
        check_bit("pmu_mode.suspend", pmu_mode.suspend, 1'b0);
        read_expect(reg_bias_off, 32'h0000_0228);   // bg_trim 4, iref_trim 0x28
        read_expect(reg_ldo_off, 32'h0000_01c8);
        read_expect(reg_osc_off, 32'h0000_54b3);
        read_expect(reg_sw_off, 32'h0000_0005);
        read_expect(reg_wd_off, 32'h0000_0002);
        read_expect(reg_adc_off, 32'h0000_0010);    // sample_cnt 1
        read_expect(reg_status_off, 32'h0);
        read_expect(reg_mode_off, 32'h0000_0010);
        read_expect(reg_boot_off, 32'h0000_0010);
        read_expect(reg_int_off, 32'h0);
    endtask

    task automatic test_write_readback();
        logic [23:0] addr;
        logic [31:0] wd;
        for (int round = 0; round < 3; round++)
        begin
            for (int i = 0; i < 9; i++)
            begin
                addr = rw_offset(i);
                wd   = $random(seed);
                apb_write(addr, wd);
                check_val($sformatf("outputs@0x%02h", addr), output_view(addr), wd & rw_mask(addr));
                read_expect(addr, wd & rw_mask(addr));
            end
        end
    endtask

    task automatic test_status_unmapped();
        logic [31:0] rnd;
        logic [31:0] wd;
        for (int round = 0; round < 3; round++)
        begin
            rnd = $random(seed);
            wd  = $random(seed);
            @(negedge pclk);
            status = rnd[19:0];
            apb_write(reg_int_off, wd);
            read_expect(reg_status_off, {16'h0, rnd[19:4]});    // Ready flags and ADC data
            read_expect(reg_int_off, {4'h0, rnd[3:0], 4'h0, wd[19:0]});
        end
        read_expect(24'h14, 32'h0);
        read_expect(24'h30, 32'h0);
        read_expect(24'h70, 32'h0);
    endtask

    task automatic test_adc_trigger();
        drive_setup(1'b1, reg_adc_off, 32'h0000_0418);
        drive_access();
        check_bit("adc_ctrl.trigger", adc_ctrl.trigger, 1'b0);  // Stretcher is one cycle behind
        drive_idle();
        check_bit("adc_ctrl.trigger", adc_ctrl.trigger, 1'b1);
        repeat (2)
        begin
            @(negedge pclk);
            check_bit("adc_ctrl.trigger", adc_ctrl.trigger, 1'b1);
        end
        @(negedge pclk);
        check_bit("adc_ctrl.trigger", adc_ctrl.trigger, 1'b0);
    endtask

    task automatic test_pulses();
        drive_setup(1'b1, reg_mode_off, 32'h0000_002b);
        drive_access();
        check_bit("pmu_mode.sleep", pmu_mode.sleep, 1'b1);
        check_bit("pmu_mode.suspend", pmu_mode.suspend, 1'b1);
        drive_idle();
        check_bit("pmu_mode.sleep", pmu_mode.sleep, 1'b0);
        check_bit("pmu_mode.suspend", pmu_mode.suspend, 1'b0);
        drive_setup(1'b1, reg_int_off, 32'h0003_5a5f);
        drive_access();
        check_bit("irq_ctrl.clr_en", irq_ctrl.clr_en, 1'b1);
        drive_idle();
        check_bit("irq_ctrl.clr_en", irq_ctrl.clr_en, 1'b0);
        drive_setup(1'b1, reg_int_off, 32'h0000_1234);    // Clear field zero
        drive_access();
        check_bit("irq_ctrl.clr_en", irq_ctrl.clr_en, 1'b0);
        drive_idle();
        check_bit("irq_ctrl.clr_en", irq_ctrl.clr_en, 1'b0);
    endtask

    initial
    begin
        #(timeout_ns);
        $display("Timeout: tests did not complete within %0d ns", timeout_ns);
        $display("Errors: %0d of %0d checks", errors, checks);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        pclk    = 1'b0;
        prstn   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        status  = '0;
        repeat (rst_cycles) @(posedge pclk);
        @(negedge pclk);
        prstn = 1'b1;
        test_reset_values();
        test_write_readback();
        test_status_unmapped();
        test_adc_trigger();
        test_pulses();
        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
